// ==== rtl/f2_pkg.sv ====
`default_nettype none

package f2_pkg;

    //////////////////////////////////////////////////
    // Widths

    localparam int SDR_ADDR_W = 27;
    localparam int CPU_DATA_W = 16;

    //////////////////////////////////////////////////
    // CPU bus and chip selects

    // One 68000 bus cycle as seen by the glue
    typedef struct packed {
        logic [23:0]           word_addr;
        logic [1:0]            ds_n;
        logic                  rw;
        logic [2:0]            fc;
        logic [CPU_DATA_W-1:0] wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic work;
        logic screen;
        logic color;
        logic io;
        logic object;
    } chip_sel_t;

    // Match on the high address byte
    typedef struct packed {
        logic [7:0] base;
        logic [7:0] mask;
    } region_t;

    //////////////////////////////////////////////////
    // SDRAM request

    typedef struct packed {
        logic [SDR_ADDR_W-1:0] addr;
        logic [CPU_DATA_W-1:0] data;
        logic [1:0]            be;
        logic                  rw;
        logic                  req;
    } sdr_req_t;

    //////////////////////////////////////////////////
    // Interrupts

    localparam logic [2:0] IRQ_VBLANK = 3'd5;
    localparam logic [2:0] IRQ_DMA    = 3'd6;
    localparam logic [2:0] FC_IACK    = 3'b111;

    function automatic logic region_hit(region_t r, logic [7:0] hi_byte);
        return (hi_byte & r.mask) == r.base;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/bus_decoder.sv ====
`default_nettype none

module bus_decoder #(
    parameter f2_pkg::region_t MAP_ROM    = '{base: 8'h00, mask: 8'hF8},
    parameter f2_pkg::region_t MAP_WORK   = '{base: 8'h10, mask: 8'hFF},
    parameter f2_pkg::region_t MAP_SCREEN = '{base: 8'h80, mask: 8'hF8},
    parameter f2_pkg::region_t MAP_COLOR  = '{base: 8'h20, mask: 8'hFF},
    parameter f2_pkg::region_t MAP_IO     = '{base: 8'h30, mask: 8'hFF},
    parameter f2_pkg::region_t MAP_OBJECT = '{base: 8'h90, mask: 8'hFF}
) (
    input  wire f2_pkg::cpu_bus_t bus,
    input  wire [15:0]            sdr_q,
    input  wire [15:0]            periph_q,
    input  wire [7:0]             io_q,
    output f2_pkg::chip_sel_t     cs,
    output logic [15:0]           rdata
);

    import f2_pkg::*;

    logic [7:0] hi_byte;
    logic       strobe;

    assign hi_byte = bus.word_addr[23:16];

    // Either data strobe low
    assign strobe = ~&bus.ds_n;

    //////////////////////////////////////////////////
    // Chip selects

    // First match wins
    always_comb begin
        cs = '0;
        if (strobe) begin
            if (region_hit(MAP_ROM, hi_byte)) begin
                cs.rom = 1'b1;
            end else if (region_hit(MAP_WORK, hi_byte)) begin
                cs.work = 1'b1;
            end else if (region_hit(MAP_SCREEN, hi_byte)) begin
                cs.screen = 1'b1;
            end else if (region_hit(MAP_COLOR, hi_byte)) begin
                cs.color = 1'b1;
            end else if (region_hit(MAP_IO, hi_byte)) begin
                cs.io = 1'b1;
            end else if (region_hit(MAP_OBJECT, hi_byte)) begin
                cs.object = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read data mux

    always_comb begin
        if (cs.rom || cs.work) begin
            rdata = sdr_q;
        end else if (cs.screen || cs.color || cs.object) begin
            rdata = periph_q;
        end else if (cs.io) begin
            // I/O chip sits on the low byte
            rdata = {8'h00, io_q};
        end else begin
            rdata = 16'h0000;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sdr_cpu_port.sv ====
`default_nettype none

module sdr_cpu_port #(
    parameter logic [f2_pkg::SDR_ADDR_W-1:0] ROM_SDR_BASE  = '0,
    parameter logic [f2_pkg::SDR_ADDR_W-1:0] WORK_SDR_BASE = 27'h0100000
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire f2_pkg::cpu_bus_t  bus,
    input  wire f2_pkg::chip_sel_t cs,
    input  wire                    sdr_ack,
    output f2_pkg::sdr_req_t       sdr,
    output logic                   dtack_n
);

    import f2_pkg::*;

    logic                  strobe_idle_q;
    logic                  req_q;
    logic [SDR_ADDR_W-1:0] addr_q;
    logic [CPU_DATA_W-1:0] data_q;
    logic [1:0]            be_q;
    logic                  rw_q;

    logic                  busy;
    logic                  start;
    logic [SDR_ADDR_W-1:0] next_addr;

    assign busy = req_q != sdr_ack;

    // One request per strobe assertion
    assign start = (cs.rom || cs.work) && strobe_idle_q && !busy;

    always_comb begin
        if (cs.rom) begin
            next_addr = ROM_SDR_BASE + {3'b000, bus.word_addr};
        end else begin
            // Work RAM is 64 KB
            next_addr = WORK_SDR_BASE + {11'd0, bus.word_addr[15:0]};
        end
    end

    //////////////////////////////////////////////////
    // Toggle request

    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_idle_q <= 1'b1;
            req_q <= 1'b0;
        end else begin
            strobe_idle_q <= &bus.ds_n;
            if (start) begin
                req_q <= ~req_q;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= next_addr;
            data_q <= bus.wdata;
            be_q <= ~bus.ds_n;
            rw_q <= bus.rw;
        end
    end

    assign sdr = '{addr: addr_q, data: data_q, be: be_q, rw: rw_q, req: req_q};

    // CPU waits while the request is outstanding
    assign dtack_n = busy;

endmodule

`default_nettype wire

// ==== rtl/irq_ctrl.sv ====
`default_nettype none

module irq_ctrl (
    input  wire                   clk,
    input  wire                   reset,
    input  wire f2_pkg::cpu_bus_t bus,
    input  wire                   vblank,
    input  wire                   dma_busy,
    output logic [2:0]            ipl
);

    import f2_pkg::*;

    logic vbl_prev;
    logic dma_prev;
    logic req_vbl;
    logic req_dma;

    logic iack;
    logic clr_vbl;
    logic clr_dma;

    // Level sits on A3..A1 during the acknowledge cycle
    assign iack = (bus.fc == FC_IACK) && !bus.ds_n[0];
    assign clr_vbl = iack && (bus.word_addr[3:1] == IRQ_VBLANK);
    assign clr_dma = iack && (bus.word_addr[3:1] == IRQ_DMA);

    // Previous levels track the inputs through reset
    always_ff @(posedge clk) begin
        vbl_prev <= vblank;
        dma_prev <= dma_busy;
    end

    //////////////////////////////////////////////////
    // Request latches

    always_ff @(posedge clk) begin
        if (reset) begin
            req_vbl <= 1'b0;
            req_dma <= 1'b0;
        end else begin
            // Start of vertical blank
            if (vblank && !vbl_prev) begin
                req_vbl <= 1'b1;
            end
            // End of object DMA
            if (!dma_busy && dma_prev) begin
                req_dma <= 1'b1;
            end

            // Clear wins
            if (clr_vbl) begin
                req_vbl <= 1'b0;
            end
            if (clr_dma) begin
                req_dma <= 1'b0;
            end
        end
    end

    assign ipl = req_dma ? IRQ_DMA :
                 req_vbl ? IRQ_VBLANK :
                 3'd0;

endmodule

`default_nettype wire

// ==== rtl/f2_cpu_glue.sv ====
`default_nettype none

module f2_cpu_glue #(
    // F2 address map
    parameter f2_pkg::region_t MAP_ROM    = '{base: 8'h00, mask: 8'hF8},
    parameter f2_pkg::region_t MAP_WORK   = '{base: 8'h10, mask: 8'hFF},
    parameter f2_pkg::region_t MAP_SCREEN = '{base: 8'h80, mask: 8'hF8},
    parameter f2_pkg::region_t MAP_COLOR  = '{base: 8'h20, mask: 8'hFF},
    parameter f2_pkg::region_t MAP_IO     = '{base: 8'h30, mask: 8'hFF},
    parameter f2_pkg::region_t MAP_OBJECT = '{base: 8'h90, mask: 8'hFF},

    // SDRAM layout
    parameter logic [f2_pkg::SDR_ADDR_W-1:0] ROM_SDR_BASE  = 27'h0000000,
    parameter logic [f2_pkg::SDR_ADDR_W-1:0] WORK_SDR_BASE = 27'h0100000
) (
    input  wire                    clk,
    input  wire                    reset,

    // CPU side
    input  wire f2_pkg::cpu_bus_t  bus,
    output wire [15:0]             rdata,
    output wire                    dtack_n,
    output wire [2:0]              ipl,

    // Interrupt sources
    input  wire                    vblank,
    input  wire                    dma_busy,

    // Peripherals
    output wire f2_pkg::chip_sel_t cs,
    input  wire [15:0]             periph_q,
    input  wire [7:0]              io_q,

    // SDRAM
    output wire f2_pkg::sdr_req_t  sdr,
    input  wire [15:0]             sdr_q,
    input  wire                    sdr_ack
);

    //////////////////////////////////////////////////
    // Address decode

    bus_decoder #(
        .MAP_ROM    (MAP_ROM),
        .MAP_WORK   (MAP_WORK),
        .MAP_SCREEN (MAP_SCREEN),
        .MAP_COLOR  (MAP_COLOR),
        .MAP_IO     (MAP_IO),
        .MAP_OBJECT (MAP_OBJECT)
    ) u_bus_decoder (
        .bus      (bus),
        .sdr_q    (sdr_q),
        .periph_q (periph_q),
        .io_q     (io_q),
        .cs       (cs),
        .rdata    (rdata)
    );

    //////////////////////////////////////////////////
    // ROM and work RAM in SDRAM

    sdr_cpu_port #(
        .ROM_SDR_BASE  (ROM_SDR_BASE),
        .WORK_SDR_BASE (WORK_SDR_BASE)
    ) u_sdr_cpu_port (
        .clk     (clk),
        .reset   (reset),
        .bus     (bus),
        .cs      (cs),
        .sdr_ack (sdr_ack),
        .sdr     (sdr),
        .dtack_n (dtack_n)
    );

    //////////////////////////////////////////////////
    // Interrupts

    irq_ctrl u_irq_ctrl (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .vblank   (vblank),
        .dma_busy (dma_busy),
        .ipl      (ipl)
    );

endmodule

`default_nettype wire

// ==== tests/f2_cpu_glue_chk.sv ====
`default_nettype none

module f2_cpu_glue_chk (
    input wire                    clk,
    input wire                    reset,
    input wire f2_pkg::cpu_bus_t  bus,
    input wire f2_pkg::chip_sel_t cs,
    input wire                    sdr_ack,
    input wire f2_pkg::sdr_req_t  sdr,
    input wire                    dtack_n
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic busy;

    assign busy = sdr.req != sdr_ack;

    // New request only at a strobe start in rom or work
    req_toggle: assert property (@(posedge clk) disable iff (reset)
        $changed(sdr.req) |-> $past(cs.rom || cs.work) && $past(&bus.ds_n, 2))
    else begin
        $error("sdr.req toggled outside a rom or work strobe start");
        fail_count++;
    end

    fields_stable: assert property (@(posedge clk) disable iff (reset)
        $past(busy) |-> $stable(sdr))
    else begin
        $error("sdr fields changed while a request was outstanding");
        fail_count++;
    end

    dtack_match: assert property (@(posedge clk) disable iff (reset)
        dtack_n == busy)
    else begin
        $error("dtack_n does not follow req against ack");
        fail_count++;
    end

endmodule

bind sdr_cpu_port f2_cpu_glue_chk u_chk (
    .clk     (clk),
    .reset   (reset),
    .bus     (bus),
    .cs      (cs),
    .sdr_ack (sdr_ack),
    .sdr     (sdr),
    .dtack_n (dtack_n)
);

`default_nettype wire

// ==== tests/tb_f2_cpu_glue.sv ====
`default_nettype none

module tb_f2_cpu_glue;

    timeunit 1ns;
    timeprecision 1ps;

    import f2_pkg::*;

    localparam int NUM_ROWS    = 10;
    localparam int ACK_TIMEOUT = 20;

    localparam chip_sel_t CS_NONE   = 6'b000000;
    localparam chip_sel_t CS_ROM    = 6'b100000;
    localparam chip_sel_t CS_WORK   = 6'b010000;
    localparam chip_sel_t CS_SCREEN = 6'b001000;
    localparam chip_sel_t CS_COLOR  = 6'b000100;
    localparam chip_sel_t CS_IO     = 6'b000010;
    localparam chip_sel_t CS_OBJECT = 6'b000001;

    typedef struct packed {
        logic [23:0]           word_addr;
        logic [1:0]            ds_n;
        logic                  rw;
        logic [15:0]           wdata;
        logic [15:0]           periph;
        logic [7:0]            io;
        chip_sel_t             exp_cs;
        logic [SDR_ADDR_W-1:0] exp_addr;
        logic [1:0]            exp_be;
    } row_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    cpu_bus_t    bus;
    logic [15:0] rdata;
    logic        dtack_n;
    logic [2:0]  ipl;
    logic        vblank;
    logic        dma_busy;
    chip_sel_t   cs;
    logic [15:0] periph_q;
    logic [7:0]  io_q;
    sdr_req_t    sdr;
    logic [15:0] sdr_q = 16'h0000;
    logic        sdr_ack = 1'b0;

    row_t     stim [NUM_ROWS];
    sdr_req_t captured[$];
    int       errors = 0;
    integer   seed = 32'h75f7_ff0d;
    logic     model_busy = 1'b0;
    int       model_cnt = 0;

    f2_cpu_glue u_dut (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .rdata    (rdata),
        .dtack_n  (dtack_n),
        .ipl      (ipl),
        .vblank   (vblank),
        .dma_busy (dma_busy),
        .cs       (cs),
        .periph_q (periph_q),
        .io_q     (io_q),
        .sdr      (sdr),
        .sdr_q    (sdr_q),
        .sdr_ack  (sdr_ack)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // SDRAM model answering each toggle after 1 to 6 cycles

    always @(posedge clk) begin
        if (reset) begin
            sdr_ack <= 1'b0;
            model_busy <= 1'b0;
        end else if (!model_busy) begin
            if (sdr.req != sdr_ack) begin
                model_busy <= 1'b1;
                model_cnt <= 1 + ($unsigned($random(seed)) % 6);
                captured.push_back(sdr);
            end
        end else if (model_cnt == 1) begin
            model_busy <= 1'b0;
            sdr_ack <= sdr.req;
            sdr_q <= sdr.addr[15:0] ^ 16'hA5A5;
        end else begin
            model_cnt <= model_cnt - 1;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR: %s = %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Columns are word_addr, ds_n, rw, wdata, periph_q, io_q, cs, sdr addr and be
    task automatic load_stimulus();
        stim[0] = '{24'h001234, 2'b00, 1'b1, 16'h0000, 16'h0000, 8'h00, CS_ROM, 27'h0001234, 2'b11};
        stim[1] = '{24'h07FFFE, 2'b01, 1'b1, 16'h0000, 16'h0000, 8'h00, CS_ROM, 27'h007FFFE, 2'b10};
        stim[2] = '{24'h10ABCE, 2'b00, 1'b0, 16'hBEEF, 16'h0000, 8'h00, CS_WORK, 27'h010ABCE, 2'b11};
        stim[3] = '{24'h100020, 2'b10, 1'b0, 16'h0055, 16'h0000, 8'h00, CS_WORK, 27'h0100020, 2'b01};
        stim[4] = '{24'h800100, 2'b00, 1'b1, 16'h0000, 16'h1357, 8'h00, CS_SCREEN, '0, 2'b00};
        stim[5] = '{24'h200010, 2'b00, 1'b1, 16'h0000, 16'h2468, 8'h00, CS_COLOR, '0, 2'b00};
        stim[6] = '{24'h30000E, 2'b10, 1'b1, 16'h0000, 16'hFFFF, 8'hC3, CS_IO, '0, 2'b00};
        stim[7] = '{24'h900000, 2'b00, 1'b1, 16'h0000, 16'h9ABC, 8'h00, CS_OBJECT, '0, 2'b00};
        // Unmapped access and a ROM address with both strobes high
        stim[8] = '{24'h400000, 2'b00, 1'b1, 16'h0000, 16'hFFFF, 8'hFF, CS_NONE, '0, 2'b00};
        stim[9] = '{24'h000100, 2'b11, 1'b1, 16'h0000, 16'hFFFF, 8'hFF, CS_NONE, '0, 2'b00};
    endtask

    function automatic logic [15:0] expected_rdata(row_t r);
        if (r.exp_cs.rom || r.exp_cs.work) begin
            return r.exp_addr[15:0] ^ 16'hA5A5;
        end else if (r.exp_cs.screen || r.exp_cs.color || r.exp_cs.object) begin
            return r.periph;
        end else if (r.exp_cs.io) begin
            return {8'h00, r.io};
        end
        return 16'h0000;
    endfunction

    // Starts and ends at a falling edge
    task automatic apply_row(input int idx);
        row_t     r;
        int       n_before;
        int       waited;
        logic     sdram_hit;
        sdr_req_t got;
        r = stim[idx];
        sdram_hit = r.exp_cs.rom || r.exp_cs.work;
        n_before = captured.size();
        bus.word_addr = r.word_addr;
        bus.ds_n = r.ds_n;
        bus.rw = r.rw;
        bus.wdata = r.wdata;
        periph_q = r.periph;
        io_q = r.io;
        @(negedge clk);
        check("cs", cs, r.exp_cs);
        check("dtack_n", dtack_n, sdram_hit);
        waited = 0;
        while (dtack_n && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (dtack_n) begin
            $display("Row %0d: the SDRAM never acknowledged and dtack_n stayed high", idx);
            errors++;
        end
        check("rdata", rdata, expected_rdata(r));
        // Strobes stay low for one more cycle after DTACK
        @(negedge clk);
        check("dtack_n", dtack_n, 1'b0);
        bus.ds_n = 2'b11;
        @(negedge clk);
        check("sdr request count", captured.size() - n_before, sdram_hit ? 1 : 0);
        if (sdram_hit && captured.size() > n_before) begin
            got = captured[captured.size() - 1];
            check("sdr.addr", got.addr, r.exp_addr);
            check("sdr.be", got.be, r.exp_be);
            check("sdr.rw", got.rw, r.rw);
            check("sdr.data", got.data, r.wdata);
        end
    endtask

    task automatic acknowledge(input logic [2:0] level);
        bus.word_addr = {20'hFFFFF, level, 1'b0};
        bus.fc = FC_IACK;
        bus.ds_n = 2'b10;
        @(negedge clk);
        bus.ds_n = 2'b11;
        bus.fc = 3'b101;
    endtask

    task automatic run_interrupts();
        check("ipl", ipl, 3'd0);
        vblank = 1'b1;
        @(negedge clk);
        check("ipl", ipl, IRQ_VBLANK);
        dma_busy = 1'b1;
        @(negedge clk);
        check("ipl", ipl, IRQ_VBLANK);
        dma_busy = 1'b0;
        @(negedge clk);
        check("ipl", ipl, IRQ_DMA);
        acknowledge(IRQ_DMA);
        check("ipl", ipl, IRQ_VBLANK);
        acknowledge(IRQ_VBLANK);
        check("ipl", ipl, 3'd0);
        vblank = 1'b0;
    endtask

    initial begin
        bus = '0;
        bus.ds_n = 2'b11;
        bus.rw = 1'b1;
        bus.fc = 3'b101;
        vblank = 1'b0;
        dma_busy = 1'b0;
        periph_q = 16'h0000;
        io_q = 8'h00;
        load_stimulus();
        repeat (16) @(negedge clk);
        reset = 1'b0;
        check("dtack_n", dtack_n, 1'b0);
        check("ipl", ipl, 3'd0);
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        run_interrupts();
        $display("Errors: %0d, assertion failures: %0d", errors,
                 u_dut.u_sdr_cpu_port.u_chk.fail_count);
        if (errors == 0 && u_dut.u_sdr_cpu_port.u_chk.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/f2_pkg.sv
rtl/bus_decoder.sv
rtl/sdr_cpu_port.sv
rtl/irq_ctrl.sv
rtl/f2_cpu_glue.sv
tests/f2_cpu_glue_chk.sv
tests/tb_f2_cpu_glue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_f2_cpu_glue
FLAGS     ?= --binary --timing --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+100
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLAGS RUN_FLAGS OBJ_DIR FILELIST"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
